// File: rtl/bfifo_pkg.sv
package bfifo_pkg;

  ////////////////////////////////////////////////////////////
  // Default geometry
  ////////////////////////////////////////////////////////////
  localparam int BFIFO_DWID      = 18;  // Data width
  localparam int BFIFO_AWID      = 6;   // RAM address width, 64 deep
  localparam int BFIFO_AFULL_TH  = 4;   // Free slots at or below which nafull drops
  localparam int BFIFO_AEMPTY_TH = 4;   // Stored words at or below which naempty drops

  ////////////////////////////////////////////////////////////
  // Pointer arithmetic
  ////////////////////////////////////////////////////////////

  // Words between two wrap-bit pointers of width awid+1.
  // The difference is taken modulo 2^(awid+1), so a full RAM
  // (same index, opposite wrap bit) gives 2^awid and equal
  // pointers give zero.
  function automatic logic [31:0] ptr_gap(
    input logic [31:0] head,                     // Leading pointer, zero extended
    input logic [31:0] tail,                     // Trailing pointer, zero extended
    input int unsigned awid                      // Address width without wrap bit
  );
    logic [31:0] mask;                           // Keeps index plus wrap bit
    logic [31:0] diff;                           // Raw modular difference
    mask = (32'd1 << (awid + 1)) - 32'd1;
    diff = head - tail;
    return diff & mask;
  endfunction

endpackage

// File: rtl/bfifo_sdp_ram.sv
`timescale 1ns/1ps
module bfifo_sdp_ram #(
  parameter int AWID = 6,                        // Address width
  parameter int DWID = 18                        // Data width
) (
  input  logic            clka,                  // Clock for both ports
  input  logic            wen,                   // Write enable
  input  logic [AWID-1:0] waddr,                 // Write address
  input  logic [DWID-1:0] wdata,                 // Write data
  input  logic            ren,                   // Read enable
  input  logic [AWID-1:0] raddr,                 // Read address
  output logic [DWID-1:0] rdata                  // Registered read data
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  localparam int DEPTH = 2 ** AWID;              // Words in array

  logic [DWID-1:0] mem [DEPTH];                  // Data array, contents not reset

  // Write port
  always_ff @(posedge clka) begin
    if (wen) begin
      mem[waddr] <= wdata;                       // One word per edge
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // One cycle of latency. The register holds the last word
  // fetched, which the read controller uses as the FIFO head.
  always_ff @(posedge clka) begin
    if (ren) begin
      rdata <= mem[raddr];                       // Load addressed word
    end
  end

endmodule

// File: rtl/bfifo_wr_ctrl.sv
`timescale 1ns/1ps
module bfifo_wr_ctrl import bfifo_pkg::*; #(
  parameter int AWID     = 6,                    // RAM address width
  parameter int DWID     = 18,                   // Data width
  parameter int AFULL_TH = 4                     // Almost-full level in free slots
) (
  input  logic            clka,                  // Clock
  input  logic            rstb,                  // Sync reset, active high
  input  logic            wen,                   // Write strobe from user
  input  logic [DWID-1:0] wdata,                 // Write data from user
  input  logic [AWID:0]   rptr,                  // Read pointer with wrap bit
  output logic [AWID:0]   wptr,                  // Write pointer with wrap bit
  output logic            ram_wen,               // Accepted write to RAM
  output logic [AWID-1:0] ram_waddr,             // RAM write address
  output logic [DWID-1:0] ram_wdata,             // RAM write data
  output logic            nfull,                 // Room for at least one word
  output logic            nafull,                // Above almost-full level
  output logic            woverflow,             // Sticky, write while full
  output logic [AWID:0]   cnt_free               // Free RAM slots
);

  ////////////////////////////////////////////////////////////
  // Local constants and nets
  ////////////////////////////////////////////////////////////
  localparam int DEPTH = 2 ** AWID;              // RAM words

  localparam logic [AWID:0] DEPTH_W = (AWID+1)'(DEPTH);     // Depth at count width
  localparam logic [AWID:0] AF_LVL  = (AWID+1)'(AFULL_TH);  // Threshold at count width

  logic [AWID:0] gap;                            // Words written but not yet fetched

  ////////////////////////////////////////////////////////////
  // RAM write port
  ////////////////////////////////////////////////////////////

  // Strobe only counts while there is room
  assign ram_wen   = wen & nfull;                // Gate by not-full level
  assign ram_waddr = wptr[AWID-1:0];             // Drop wrap bit for RAM index
  assign ram_wdata = wdata;                      // Data goes straight to RAM

  // Write pointer
  always_ff @(posedge clka) begin
    if (rstb) begin
      wptr <= '0;                                // Start at slot 0
    end else if (ram_wen) begin
      wptr <= wptr + 1'b1;                       // Wraps with wrap bit toggling
    end
  end

  ////////////////////////////////////////////////////////////
  // Free count and full flags
  ////////////////////////////////////////////////////////////

  // rptr moves when a word leaves the RAM for the output register,
  // so the gap is RAM occupancy only
  assign gap = (AWID+1)'(ptr_gap(32'(wptr), 32'(rptr), AWID));

  assign cnt_free = DEPTH_W - gap;               // Slots left in RAM
  assign nfull    = (cnt_free != '0);            // Any slot left
  assign nafull   = (cnt_free > AF_LVL);         // Clear of almost-full band

  // Overflow, held until reset
  always_ff @(posedge clka) begin
    if (rstb) begin
      woverflow <= 1'b0;
    end else if (wen && !nfull) begin
      woverflow <= 1'b1;                         // Word dropped
    end
  end

endmodule

// File: rtl/bfifo_rd_ctrl.sv
`timescale 1ns/1ps
module bfifo_rd_ctrl import bfifo_pkg::*; #(
  parameter int AWID      = 6,                   // RAM address width
  parameter int AEMPTY_TH = 4                    // Almost-empty level in words
) (
  input  logic            clka,                  // Clock
  input  logic            rstb,                  // Sync reset, active high
  input  logic            ren,                   // Pop strobe from user
  input  logic [AWID:0]   wptr,                  // Write pointer with wrap bit
  output logic [AWID:0]   rptr,                  // Read pointer with wrap bit
  output logic            ram_ren,               // RAM fetch
  output logic [AWID-1:0] ram_raddr,             // RAM read address
  output logic            nempty,                // Head word valid on rdata
  output logic            naempty,               // Above almost-empty level
  output logic            roverflow,             // Sticky, pop while empty
  output logic [AWID:0]   cnt_used               // Words held, RAM plus head
);

  ////////////////////////////////////////////////////////////
  // Local constants and nets
  ////////////////////////////////////////////////////////////
  localparam logic [AWID:0] AE_LVL = (AWID+1)'(AEMPTY_TH);  // Threshold at count width

  logic [AWID:0] gap;                            // Words still in RAM
  logic          ram_has;                        // RAM holds at least one word
  logic          out_vld;                        // RAM output register holds head
  logic          pop;                            // Accepted pop of head word

  ////////////////////////////////////////////////////////////
  // RAM occupancy
  ////////////////////////////////////////////////////////////
  assign gap     = (AWID+1)'(ptr_gap(32'(wptr), 32'(rptr), AWID));
  assign ram_has = (gap != '0);                  // Something to fetch

  ////////////////////////////////////////////////////////////
  // Fall-through fetch
  ////////////////////////////////////////////////////////////

  // The RAM read register doubles as the head slot. It is
  // refilled when it is empty or when its word leaves this
  // cycle, so a stream of pops runs at one word per clock.
  assign pop       = ren & out_vld;              // Gate by not-empty level
  assign ram_ren   = ram_has & (~out_vld | pop); // Refill head slot
  assign ram_raddr = rptr[AWID-1:0];             // Drop wrap bit for RAM index

  // Read pointer, counts words moved into the head slot
  always_ff @(posedge clka) begin
    if (rstb) begin
      rptr <= '0;
    end else if (ram_ren) begin
      rptr <= rptr + 1'b1;                       // Next stored word
    end
  end

  // Head valid flag
  always_ff @(posedge clka) begin
    if (rstb) begin
      out_vld <= 1'b0;                           // Nothing on rdata
    end else if (ram_ren) begin
      out_vld <= 1'b1;                           // Fresh word lands next edge
    end else if (pop) begin
      out_vld <= 1'b0;                           // Head gone, RAM dry
    end
  end

  assign nempty = out_vld;                       // Valid head is not-empty

  ////////////////////////////////////////////////////////////
  // Used count and flags
  ////////////////////////////////////////////////////////////
  assign cnt_used = gap + {{AWID{1'b0}}, out_vld};   // RAM words plus head
  assign naempty  = (cnt_used > AE_LVL);             // Clear of almost-empty band

  // Underflow, held until reset
  always_ff @(posedge clka) begin
    if (rstb) begin
      roverflow <= 1'b0;
    end else if (ren && !out_vld) begin
      roverflow <= 1'b1;                         // Pop with nothing to give
    end
  end

endmodule

// File: rtl/bfifo_top.sv
`timescale 1ns/1ps
module bfifo_top import bfifo_pkg::*; #(
  parameter int DWID      = BFIFO_DWID,          // Data width
  parameter int AWID      = BFIFO_AWID,          // RAM address width
  parameter int AFULL_TH  = BFIFO_AFULL_TH,      // Almost-full level
  parameter int AEMPTY_TH = BFIFO_AEMPTY_TH      // Almost-empty level
) (
  input  logic            clka,                  // Clock
  input  logic            rstb,                  // Sync reset, active high
  // Write side
  input  logic            wen,                   // Write strobe
  input  logic [DWID-1:0] wdata,                 // Write data
  output logic            nfull,                 // Not full
  output logic            nafull,                // Not almost full
  output logic            woverflow,             // Sticky write overflow
  output logic [AWID:0]   cnt_free,              // Free RAM slots
  // Read side
  input  logic            ren,                   // Pop strobe
  output logic [DWID-1:0] rdata,                 // Head word, fall-through
  output logic            nempty,                // Not empty
  output logic            naempty,               // Not almost empty
  output logic            roverflow,             // Sticky read overflow
  output logic [AWID:0]   cnt_used               // Words held
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////
  logic [AWID:0]   wptr;                         // Write pointer to read side
  logic [AWID:0]   rptr;                         // Read pointer to write side
  logic            ram_wen;                      // Accepted write
  logic [AWID-1:0] ram_waddr;                    // RAM write index
  logic [DWID-1:0] ram_wdata;                    // RAM write data
  logic            ram_ren;                      // Head refill
  logic [AWID-1:0] ram_raddr;                    // RAM read index

  ////////////////////////////////////////////////////////////
  // Write controller
  ////////////////////////////////////////////////////////////
  bfifo_wr_ctrl #(
    .AWID      ( AWID      ),
    .DWID      ( DWID      ),
    .AFULL_TH  ( AFULL_TH  )
  ) u_wr (
    .clka      ( clka      ),
    .rstb      ( rstb      ),
    .wen       ( wen       ),
    .wdata     ( wdata     ),
    .rptr      ( rptr      ),                    // For free count
    .wptr      ( wptr      ),
    .ram_wen   ( ram_wen   ),
    .ram_waddr ( ram_waddr ),
    .ram_wdata ( ram_wdata ),
    .nfull     ( nfull     ),
    .nafull    ( nafull    ),
    .woverflow ( woverflow ),
    .cnt_free  ( cnt_free  )
  );

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  bfifo_sdp_ram #(
    .AWID      ( AWID      ),
    .DWID      ( DWID      )
  ) u_ram (
    .clka      ( clka      ),
    .wen       ( ram_wen   ),
    .waddr     ( ram_waddr ),
    .wdata     ( ram_wdata ),
    .ren       ( ram_ren   ),
    .raddr     ( ram_raddr ),
    .rdata     ( rdata     )                     // Read register is the head
  );

  ////////////////////////////////////////////////////////////
  // Read controller
  ////////////////////////////////////////////////////////////
  bfifo_rd_ctrl #(
    .AWID      ( AWID      ),
    .AEMPTY_TH ( AEMPTY_TH )
  ) u_rd (
    .clka      ( clka      ),
    .rstb      ( rstb      ),
    .ren       ( ren       ),
    .wptr      ( wptr      ),                    // For used count
    .rptr      ( rptr      ),
    .ram_ren   ( ram_ren   ),
    .ram_raddr ( ram_raddr ),
    .nempty    ( nempty    ),
    .naempty   ( naempty   ),
    .roverflow ( roverflow ),
    .cnt_used  ( cnt_used  )
  );

endmodule

// File: sim/bfifo_tb.sv
`timescale 1ns/1ps
module bfifo_tb import bfifo_pkg::*;;

  ////////////////////////////////////////////////////////////
  // Geometry and signals
  ////////////////////////////////////////////////////////////
  localparam int AWID  = 3;                      // Depth 8 and capacity 9
  localparam int DWID  = BFIFO_DWID;
  localparam int DEPTH = 2 ** AWID;
  localparam int CAP   = DEPTH + 1;              // RAM plus head register

  logic            clka;
  logic            rstb;
  logic            wen;
  logic [DWID-1:0] wdata;
  logic            ren;
  logic            nfull;
  logic            nafull;
  logic            woverflow;
  logic [AWID:0]   cnt_free;
  logic [DWID-1:0] rdata;
  logic            nempty;
  logic            naempty;
  logic            roverflow;
  logic [AWID:0]   cnt_used;

  logic [DWID-1:0] ref_q[$];                     // Reference queue, oldest first
  int              exp_size;                     // Words the FIFO should hold
  logic [DWID-1:0] exp_head;                     // Word expected on rdata
  logic            exp_vld;                      // Head word expected valid
  int              exp_free;                     // Free RAM slots expected
  logic            exp_wovf;                     // Expected sticky flags
  logic            exp_rovf;
  int              seed;                         // Random seed
  int              pops;                         // Words removed so far

  bfifo_top #(
    .AWID      ( AWID      )
  ) dut0 (
    .clka      ( clka      ),
    .rstb      ( rstb      ),
    .wen       ( wen       ),
    .wdata     ( wdata     ),
    .nfull     ( nfull     ),
    .nafull    ( nafull    ),
    .woverflow ( woverflow ),
    .cnt_free  ( cnt_free  ),
    .ren       ( ren       ),
    .rdata     ( rdata     ),
    .nempty    ( nempty    ),
    .naempty   ( naempty   ),
    .roverflow ( roverflow ),
    .cnt_used  ( cnt_used  )
  );

  initial begin
    clka = 1'b0;
    forever #50 clka = ~clka;                    // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////
  task automatic fail_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped on first error");
  endtask

  task automatic timeout_fail(input string msg);
    $display("Timeout at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped on timeout");
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model updated on the same edge as the DUT
  ////////////////////////////////////////////////////////////
  always @(posedge clka) begin
    if (rstb) begin
      ref_q.delete();                            // FIFO empties on reset
      exp_vld  = 1'b0;
      exp_wovf = 1'b0;
      exp_rovf = 1'b0;
      pops     = 0;
    end else begin
      if (wen && exp_free == 0) exp_wovf = 1'b1; // Dropped write
      if (ren && !exp_vld) exp_rovf = 1'b1;      // Pop of empty FIFO
      if (ren && exp_vld) begin
        void'(ref_q.pop_front());                // Head leaves
        pops++;
      end
      exp_vld = (ref_q.size() != 0);             // New words show up one edge later
      if (wen && exp_free != 0) ref_q.push_back(wdata);  // Accepted write
    end
    exp_size = ref_q.size();
    exp_free = DEPTH - exp_size + int'(exp_vld); // Head word takes no RAM slot
    exp_head = (ref_q.size() != 0) ? ref_q[0] : '0;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_reset: assert property (@(posedge clka) $fell(rstb) |->
      (!nempty && !naempty && !woverflow && !roverflow && nfull && nafull &&
       cnt_free == DEPTH && cnt_used == 0 && dut0.wptr == 0 && dut0.rptr == 0))
    else fail_mismatch("outputs not at reset values after reset");

  a_head: assert property (@(posedge clka) disable iff (rstb)
      nempty |-> rdata == exp_head)
    else fail_mismatch("rdata is not the oldest queued word");

  a_empty: assert property (@(posedge clka) disable iff (rstb)
      (exp_size == 0) |-> !nempty)
    else fail_mismatch("nempty high with nothing queued");

  // Head slot refills one edge after it goes dry
  a_fill: assert property (@(posedge clka) disable iff (rstb)
      (exp_size != 0 && !nempty) |=> nempty)
    else fail_mismatch("head word late on rdata");

  a_used: assert property (@(posedge clka) disable iff (rstb)
      int'(cnt_used) == exp_size)
    else fail_mismatch("cnt_used differs from queue size");

  a_free: assert property (@(posedge clka) disable iff (rstb)
      int'(cnt_free) == exp_free)
    else fail_mismatch("cnt_free differs from free RAM slots");

  a_nfull: assert property (@(posedge clka) disable iff (rstb)
      nfull == (exp_free != 0))
    else fail_mismatch("nfull disagrees with free RAM slots");

  a_nafull: assert property (@(posedge clka) disable iff (rstb)
      nafull == (exp_free > BFIFO_AFULL_TH))
    else fail_mismatch("nafull disagrees with free RAM slots");

  a_naempty: assert property (@(posedge clka) disable iff (rstb)
      naempty == (exp_size > BFIFO_AEMPTY_TH))
    else fail_mismatch("naempty disagrees with stored words");

  a_wovf: assert property (@(posedge clka) disable iff (rstb)
      woverflow == exp_wovf)
    else fail_mismatch("woverflow wrong");

  a_rovf: assert property (@(posedge clka) disable iff (rstb)
      roverflow == exp_rovf)
    else fail_mismatch("roverflow wrong");

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clka);
    #10;                                         // Drive after the edge
  endtask

  task automatic wait_nempty(input int limit);
    int n;
    n = 0;
    while (!nempty && n < limit) begin
      next_cycle();
      n++;
    end
    if (!nempty) timeout_fail("nempty never rose after a write");
  endtask

  task automatic drain_fifo(input int limit);
    int n;
    n = 0;
    wen = 1'b0;
    ren = 1'b1;                                  // Pop every cycle
    while (exp_size != 0 && n < limit) begin
      next_cycle();
      n++;
    end
    ren = 1'b0;
    if (exp_size != 0) timeout_fail("FIFO did not drain in time");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    seed  = 70625;
    rstb  = 1'b1;
    wen   = 1'b0;
    ren   = 1'b0;
    wdata = '0;
    repeat (5) next_cycle();                     // Reset for 5 edges
    rstb = 1'b0;
    repeat (2) next_cycle();

    // Single word through an empty FIFO
    wen   = 1'b1;
    wdata = DWID'($random(seed));
    next_cycle();
    wen = 1'b0;
    wait_nempty(4);
    drain_fifo(4);

    // Pop while empty
    ren = 1'b1;
    next_cycle();
    ren = 1'b0;
    next_cycle();
    assert (roverflow) else fail_mismatch("roverflow not set by empty pop");

    // Fill with no reads up to the capacity of 9
    for (int i = 0; i < CAP; i++) begin
      assert (nfull) else fail_mismatch("nfull low before capacity");
      wen   = 1'b1;
      wdata = DWID'($random(seed));
      next_cycle();
    end
    wen = 1'b0;
    assert (!nfull && exp_size == CAP)
      else fail_mismatch("nfull still high after ninth write");
    wen   = 1'b1;
    wdata = 18'h2aaaa;                           // Dropped word
    next_cycle();
    wen = 1'b0;
    next_cycle();
    assert (woverflow && exp_size == CAP)
      else fail_mismatch("tenth write not flagged as overflow");
    drain_fifo(CAP + 4);

    // Random traffic that runs fuller then emptier
    for (int c = 0; c < 300; c++) begin
      r     = $random(seed);
      wdata = DWID'($random(seed));
      if (c < 150) begin
        wen = r[0] | r[1];                       // About 3 in 4
        ren = r[2];
      end else begin
        wen = r[0];
        ren = r[1] | r[2];
      end
      next_cycle();
    end
    drain_fifo(CAP + 4);
    next_cycle();
    assert (!nempty && cnt_used == 0)
      else fail_mismatch("FIFO not empty after drain");

    $display("Popped %0d words", pops);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
rtl/bfifo_pkg.sv
rtl/bfifo_sdp_ram.sv
rtl/bfifo_wr_ctrl.sv
rtl/bfifo_rd_ctrl.sv
rtl/bfifo_top.sv
sim/bfifo_tb.sv
